/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module tb_ahb_cap -f verilog.f -Mdir obj_dir
	./obj_dir/Vtb_ahb_cap > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	@cat $(LOG)
	@! grep -q "TEST FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* logic/ahb_cap_config.svh */
`ifndef AHB_CAP_CONFIG_SVH
`define AHB_CAP_CONFIG_SVH

// Index width of the read-data buffer, giving 2**DEPTH words.
`define AHB_CAP_DEPTH 4

// Width of hwdata, hrdata, the operands and the buffer words.
`define AHB_CAP_WIDTH 32

`endif

/* logic/ahb_cap_pkg.sv */
package ahb_cap_pkg;

`include "ahb_cap_config.svh"

    typedef logic [`AHB_CAP_WIDTH-1:0] word_t;
    typedef logic [31:0]               haddr_t;
    typedef logic [`AHB_CAP_DEPTH-1:0] buf_idx_t;

    // Transfer control fields as driven on the bus.
    typedef struct packed {
        logic [2:0] hsize;
        logic [2:0] hburst;
        logic [3:0] hprot;
        logic [2:0] htrans;  // Bits [1:0] carry the AHB code.
    } ahb_ctrl_t;

    // One captured command.
    typedef struct packed {
        haddr_t    haddr;
        logic      write;
        buf_idx_t  idx;
        ahb_ctrl_t ctrl;
        word_t     wdata;
    } ahb_req_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        FINISH
    } seq_state_t;

endpackage

/* logic/ahb_cap_top.sv */
`timescale 1ns/100ps

module ahb_cap_top (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      start,
    input  logic                                      write,
    input  ahb_cap_pkg::buf_idx_t                     buf_idx,
    input  ahb_cap_pkg::haddr_t                       haddr_in,
    input  ahb_cap_pkg::word_t                        a,
    input  ahb_cap_pkg::word_t                        b,
    input  ahb_cap_pkg::ahb_ctrl_t                    ctrl_in,
    input  logic [$bits(ahb_cap_pkg::ahb_ctrl_t)-1:0] ctrl_en,
    input  ahb_cap_pkg::buf_idx_t                     rd_idx,
    output ahb_cap_pkg::word_t                        data_out,
    output logic                                      done,
    output logic                                      resp,
    output logic                                      busy,
    output ahb_cap_pkg::haddr_t                       haddr,
    output logic                                      hwrite,
    output logic [2:0]                                hsize,
    output logic [2:0]                                hburst,
    output logic [3:0]                                hprot,
    output logic [2:0]                                htrans,
    output ahb_cap_pkg::word_t                        hwdata,
    input  ahb_cap_pkg::word_t                        hrdata,
    input  logic                                      hready,
    input  logic                                      hresp
);

    ahb_cap_pkg::ahb_req_t cmd;
    logic                  cmd_load;
    logic                  rslt_valid;
    logic                  rslt_write;
    logic                  rslt_err;
    ahb_cap_pkg::buf_idx_t rslt_idx;
    ahb_cap_pkg::word_t    rslt_data;

    ctrl_capture u_ctrl_capture (
        .clk(clk), .rst(rst), .start(start), .write(write), .buf_idx(buf_idx),
        .haddr_in(haddr_in), .a(a), .b(b), .ctrl_in(ctrl_in), .ctrl_en(ctrl_en),
        .busy(busy), .cmd(cmd), .cmd_load(cmd_load)
    );

    ahb_master_seq u_ahb_master_seq (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_load(cmd_load), .hready(hready),
        .hresp(hresp), .hrdata(hrdata), .haddr(haddr), .hwrite(hwrite),
        .hsize(hsize), .hburst(hburst), .hprot(hprot), .htrans(htrans),
        .hwdata(hwdata), .busy(busy), .rslt_valid(rslt_valid),
        .rslt_write(rslt_write), .rslt_err(rslt_err), .rslt_idx(rslt_idx),
        .rslt_data(rslt_data)
    );

    capture_ram u_capture_ram (
        .clk(clk), .rst(rst), .rslt_valid(rslt_valid), .rslt_write(rslt_write),
        .rslt_err(rslt_err), .rslt_idx(rslt_idx), .rslt_data(rslt_data),
        .rd_idx(rd_idx), .data_out(data_out), .done(done), .resp(resp)
    );

endmodule

/* logic/ahb_master_seq.sv */
`timescale 1ns/100ps

module ahb_master_seq (
    input  logic                  clk,
    input  logic                  rst,
    input  ahb_cap_pkg::ahb_req_t cmd,
    input  logic                  cmd_load,
    input  logic                  hready,
    input  logic                  hresp,
    input  ahb_cap_pkg::word_t    hrdata,
    output ahb_cap_pkg::haddr_t   haddr,
    output logic                  hwrite,
    output logic [2:0]            hsize,
    output logic [2:0]            hburst,
    output logic [3:0]            hprot,
    output logic [2:0]            htrans,
    output ahb_cap_pkg::word_t    hwdata,
    output logic                  busy,
    output logic                  rslt_valid,
    output logic                  rslt_write,
    output logic                  rslt_err,
    output ahb_cap_pkg::buf_idx_t rslt_idx,
    output ahb_cap_pkg::word_t    rslt_data
);

    ahb_cap_pkg::seq_state_t state;
    logic                    xfer;

    // NONSEQ and SEQ both have bit 1 set; IDLE and BUSY do not.
    assign xfer = cmd.ctrl.htrans[1];

    assign busy       = cmd_load || (state != ahb_cap_pkg::IDLE);
    assign rslt_valid = (state == ahb_cap_pkg::FINISH);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ahb_cap_pkg::IDLE;
        end else begin
            case (state)
                ahb_cap_pkg::IDLE: begin
                    if (cmd_load) begin
                        state <= xfer ? ahb_cap_pkg::ADDR : ahb_cap_pkg::FINISH;
                    end
                end
                ahb_cap_pkg::ADDR:   state <= ahb_cap_pkg::DATA;  // Always one cycle.
                ahb_cap_pkg::DATA: begin
                    if (hready) begin
                        state <= ahb_cap_pkg::FINISH;
                    end
                end
                default: state <= ahb_cap_pkg::IDLE;
            endcase
        end
    end

    // htrans is only non-IDLE in the address phase.
    always_ff @(posedge clk) begin
        if (rst) begin
            htrans   <= '0;
            hwrite   <= 1'b0;
            hsize    <= '0;
            hburst   <= '0;
            hprot    <= '0;
            rslt_err <= 1'b0;
        end else begin
            htrans <= (cmd_load && xfer) ? cmd.ctrl.htrans : 3'b000;
            if (cmd_load) begin
                hwrite   <= cmd.write;
                hsize    <= cmd.ctrl.hsize;
                hburst   <= cmd.ctrl.hburst;  // Forwarded only.
                hprot    <= cmd.ctrl.hprot;
                rslt_err <= 1'b0;
            end else if (state == ahb_cap_pkg::DATA && hready) begin
                rslt_err <= hresp;
            end
        end
    end

    // hwdata stays put for the whole data phase.
    always_ff @(posedge clk) begin
        if (cmd_load) begin
            haddr      <= cmd.haddr;
            hwdata     <= cmd.wdata;
            rslt_write <= cmd.write || !xfer;  // No data to keep without a transfer.
            rslt_idx   <= cmd.idx;
        end
        if (state == ahb_cap_pkg::DATA && hready) begin
            rslt_data <= hrdata;
        end
    end

endmodule

/* logic/capture_ram.sv */
`timescale 1ns/100ps

module capture_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rslt_valid,
    input  logic                  rslt_write,
    input  logic                  rslt_err,
    input  ahb_cap_pkg::buf_idx_t rslt_idx,
    input  ahb_cap_pkg::word_t    rslt_data,
    input  ahb_cap_pkg::buf_idx_t rd_idx,
    output ahb_cap_pkg::word_t    data_out,
    output logic                  done,
    output logic                  resp
);

    localparam int num_words = 2 ** $bits(ahb_cap_pkg::buf_idx_t);

    ahb_cap_pkg::word_t mem [num_words];
    logic               keep;

    // Only reads that ended OKAY land in the buffer.
    assign keep = rslt_valid && !rslt_write && !rslt_err;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_words; i++) begin
                mem[i] <= '0;
            end
        end else if (keep) begin
            mem[rslt_idx] <= rslt_data;
        end
    end

    always_ff @(posedge clk) begin
        data_out <= mem[rd_idx];  // Old word on a same-cycle write.
    end

    // resp holds the last command's status until the next one ends.
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
            resp <= 1'b0;
        end else begin
            done <= rslt_valid;
            if (rslt_valid) begin
                resp <= rslt_err;
            end
        end
    end

endmodule

/* logic/ctrl_capture.sv */
`timescale 1ns/100ps

module ctrl_capture (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      start,
    input  logic                                      write,
    input  ahb_cap_pkg::buf_idx_t                     buf_idx,
    input  ahb_cap_pkg::haddr_t                       haddr_in,
    input  ahb_cap_pkg::word_t                        a,
    input  ahb_cap_pkg::word_t                        b,
    input  ahb_cap_pkg::ahb_ctrl_t                    ctrl_in,
    input  logic [$bits(ahb_cap_pkg::ahb_ctrl_t)-1:0] ctrl_en,
    input  logic                                      busy,
    output ahb_cap_pkg::ahb_req_t                     cmd,
    output logic                                      cmd_load
);

    ahb_cap_pkg::ahb_ctrl_t ctrl;
    ahb_cap_pkg::word_t     sum;
    logic                   take;

    assign take = start && !busy;  // Starts during a command are dropped.
    assign sum  = a + b;           // Carry out is lost.

    // Each control bit follows ctrl_in only while its own enable is set.
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else begin
            ctrl <= (ctrl & ~ctrl_en) | (ctrl_in & ctrl_en);
        end
    end

    // Command fields. ctrl is taken before this cycle's enables apply.
    always_ff @(posedge clk) begin
        if (take) begin
            cmd.haddr <= haddr_in;
            cmd.write <= write;
            cmd.idx   <= buf_idx;
            cmd.ctrl  <= ctrl;
            cmd.wdata <= sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_load <= 1'b0;
        end else begin
            cmd_load <= take;
        end
    end

endmodule

/* tests/ahb_cap_asserts.sv */
`timescale 1ns/100ps

module ahb_cap_asserts (
    input logic                    clk,
    input logic                    rst,
    input logic [2:0]              htrans,
    input logic                    hready,
    input ahb_cap_pkg::word_t      hwdata,
    input ahb_cap_pkg::seq_state_t state,
    input logic                    busy,
    input logic                    rslt_valid
);

    // Address phase is a single cycle.
    a_nonseq_once: assert property (@(posedge clk) disable iff (rst)
        (htrans[1:0] == 2'b10) |=> (htrans[1:0] != 2'b10))
        else $error("htrans held NONSEQ for more than one cycle");

    a_hwdata_hold: assert property (@(posedge clk) disable iff (rst)
        (state == ahb_cap_pkg::DATA && !hready) |=> $stable(hwdata))
        else $error("hwdata changed during a wait state");

    // No start is taken in the finish cycle, so busy falls right after it.
    a_busy_finish: assert property (@(posedge clk) disable iff (rst)
        rslt_valid |=> !busy)
        else $error("busy stayed high after the result strobe");

endmodule

bind ahb_master_seq ahb_cap_asserts u_asserts (
    .clk(clk), .rst(rst), .htrans(htrans), .hready(hready), .hwdata(hwdata),
    .state(state), .busy(busy), .rslt_valid(rslt_valid)
);

/* tests/tb_ahb_cap.sv */
`timescale 1ns/100ps

`include "ahb_cap_config.svh"

module tb_ahb_cap;

    localparam int num_words   = 2 ** `AHB_CAP_DEPTH;
    localparam int num_cmds    = 29;
    localparam int cycle_limit = 60 * num_cmds + 200;

    logic                                      clk;
    logic                                      rst;
    logic                                      start;
    logic                                      write;
    ahb_cap_pkg::buf_idx_t                     buf_idx;
    ahb_cap_pkg::haddr_t                       haddr_in;
    ahb_cap_pkg::word_t                        a;
    ahb_cap_pkg::word_t                        b;
    ahb_cap_pkg::ahb_ctrl_t                    ctrl_in;
    logic [$bits(ahb_cap_pkg::ahb_ctrl_t)-1:0] ctrl_en;
    ahb_cap_pkg::buf_idx_t                     rd_idx;
    ahb_cap_pkg::word_t                        data_out;
    logic                                      done;
    logic                                      resp;
    logic                                      busy;
    ahb_cap_pkg::haddr_t                       haddr;
    logic                                      hwrite;
    logic [2:0]                                hsize;
    logic [2:0]                                hburst;
    logic [3:0]                                hprot;
    logic [2:0]                                htrans;
    ahb_cap_pkg::word_t                        hwdata;
    ahb_cap_pkg::word_t                        hrdata;
    logic                                      hready;
    logic                                      hresp;

    ahb_cap_pkg::ahb_ctrl_t ref_ctrl;   // Model of the per-bit capture register.
    ahb_cap_pkg::ahb_ctrl_t last_ctrl;
    ahb_cap_pkg::ahb_ctrl_t exp_ctrl;
    ahb_cap_pkg::haddr_t    exp_addr;
    logic                   exp_write;
    ahb_cap_pkg::word_t     ref_mem [256];
    ahb_cap_pkg::word_t     slave_mem [256];
    ahb_cap_pkg::word_t     ref_buf [num_words];
    int                     addr_count;
    int                     done_count;
    int                     slave_waits;
    int                     n_cmds;
    int                     n_xfers;

    ahb_cap_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic ahb_cap_pkg::ahb_ctrl_t capture_model(
        input ahb_cap_pkg::ahb_ctrl_t cur, input ahb_cap_pkg::ahb_ctrl_t din,
        input logic [$bits(ahb_cap_pkg::ahb_ctrl_t)-1:0] en);
        logic [$bits(ahb_cap_pkg::ahb_ctrl_t)-1:0] nxt;
        for (int i = 0; i < $bits(ahb_cap_pkg::ahb_ctrl_t); i++) begin
            nxt[i] = en[i] ? din[i] : cur[i];
        end
        return nxt;
    endfunction

    function automatic ahb_cap_pkg::word_t sum_model(input ahb_cap_pkg::word_t x,
                                                     input ahb_cap_pkg::word_t y);
        logic [`AHB_CAP_WIDTH:0] full;
        full = {1'b0, x} + {1'b0, y};
        return full[`AHB_CAP_WIDTH-1:0];  // Carry dropped.
    endfunction

    function automatic ahb_cap_pkg::word_t fill_word(input int i);
        return ahb_cap_pkg::word_t'(i * 32'h9E37_79B9 + 32'h0F1E_2D3C);
    endfunction

    function automatic ahb_cap_pkg::ahb_ctrl_t rand_ctrl();
        return ahb_cap_pkg::ahb_ctrl_t'(13'($urandom));
    endfunction

    function automatic ahb_cap_pkg::haddr_t rand_addr(input logic bad);
        ahb_cap_pkg::haddr_t addr;
        addr = $urandom;
        addr[1:0] = 2'b00;
        if (bad) begin
            addr[31:28] = 4'hF;  // Slave answers ERROR here.
        end else if (addr[31:28] == 4'hF) begin
            addr[31:28] = 4'h7;
        end
        return addr;
    endfunction

    task automatic check_word(input ahb_cap_pkg::word_t got, input ahb_cap_pkg::word_t want,
                              input string what);
        if (got !== want) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
            $display("TEST FAILED");
            $fatal(1, "Word mismatch");
        end
    endtask

    task automatic check_addr(input ahb_cap_pkg::haddr_t got, input ahb_cap_pkg::haddr_t want,
                              input string what);
        if (got !== want) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
            $display("TEST FAILED");
            $fatal(1, "Address mismatch");
        end
    endtask

    task automatic check_ctrl(input ahb_cap_pkg::ahb_ctrl_t got,
                              input ahb_cap_pkg::ahb_ctrl_t want, input string what);
        if (got !== want) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
            $display("TEST FAILED");
            $fatal(1, "Control mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, want);
            $display("TEST FAILED");
            $fatal(1, "Bit mismatch");
        end
    endtask

    // One clock edge, with the capture register model stepped alongside.
    task automatic tick();
        @(posedge clk);
        last_ctrl = ref_ctrl;
        if (rst) begin
            ref_ctrl = '0;
        end else begin
            ref_ctrl = capture_model(ref_ctrl, ctrl_in, ctrl_en);
        end
    endtask

    task automatic read_buf(input ahb_cap_pkg::buf_idx_t idx, output ahb_cap_pkg::word_t value);
        tick();
        rd_idx <= idx;
        tick();
        @(negedge clk);
        value = data_out;
    endtask

    task automatic run_cmd(input logic wr, input ahb_cap_pkg::haddr_t addr,
                           input ahb_cap_pkg::buf_idx_t idx, input ahb_cap_pkg::word_t x,
                           input ahb_cap_pkg::word_t y, input logic [2:0] trans,
                           input logic poke);
        int                     lat;
        int                     exp_lat;
        logic                   xfer;
        logic                   err;
        ahb_cap_pkg::ahb_ctrl_t pre;
        ahb_cap_pkg::word_t     got;
        xfer = trans[1];
        err = xfer && (addr[31:28] == 4'hF);
        repeat (2) begin
            tick();
            ctrl_in <= rand_ctrl();
            ctrl_en <= 13'($urandom);
        end
        tick();
        pre = rand_ctrl();
        pre.htrans = trans;
        ctrl_in <= pre;
        ctrl_en <= 13'($urandom) | 13'h0007;  // htrans bits always load here.
        tick();
        start <= 1'b1;
        write <= wr;
        buf_idx <= idx;
        haddr_in <= addr;
        a <= x;
        b <= y;
        ctrl_in <= rand_ctrl();
        ctrl_en <= 13'($urandom);  // Must not reach this command.
        tick();
        exp_ctrl = last_ctrl;
        exp_addr = addr;
        exp_write = wr;
        start <= 1'b0;
        ctrl_en <= '0;
        lat = 1;
        @(negedge clk);
        while (!done) begin
            tick();
            lat++;
            if (poke) begin
                start <= (lat == 2);  // Lands while busy.
            end
            @(negedge clk);
        end
        exp_lat = xfer ? 5 + slave_waits : 3;
        n_cmds++;
        if (xfer) begin
            n_xfers++;
        end
        check_word(ahb_cap_pkg::word_t'(lat), ahb_cap_pkg::word_t'(exp_lat), "start to done");
        check_bit(resp, err, "resp");
        check_bit(busy, 1'b0, "busy after done");
        if (xfer && wr && !err) begin
            ref_mem[addr[9:2]] = sum_model(x, y);
        end
        if (xfer && !wr && !err) begin
            ref_buf[idx] = ref_mem[addr[9:2]];
        end
        check_word(slave_mem[addr[9:2]], ref_mem[addr[9:2]], "slave memory word");
        check_word(ahb_cap_pkg::word_t'(addr_count), ahb_cap_pkg::word_t'(n_xfers),
                   "address phase count");
        read_buf(idx, got);
        check_word(got, ref_buf[idx], "buffer word");
        check_word(ahb_cap_pkg::word_t'(done_count), ahb_cap_pkg::word_t'(n_cmds), "done count");
    endtask

    // AHB slave with random wait states and an address monitor.
    initial begin : slave
        logic [7:0] d_idx;
        logic       d_write;
        logic       d_err;
        logic       d_active;
        int         d_left;
        hready <= 1'b1;
        hresp <= 1'b0;
        hrdata <= '0;
        d_active = 1'b0;
        addr_count = 0;
        done_count = 0;
        for (int i = 0; i < 256; i++) begin
            slave_mem[i] = fill_word(i);
        end
        forever begin
            @(posedge clk);
            if (done) begin
                done_count++;
            end
            if (d_active && hready) begin
                if (d_write && !d_err) begin
                    slave_mem[d_idx] = hwdata;
                end
                d_active = 1'b0;
                hresp <= 1'b0;
            end else if (d_active) begin
                d_left--;
            end
            if (hready && htrans[1]) begin
                addr_count++;
                check_ctrl(ahb_cap_pkg::ahb_ctrl_t'({hsize, hburst, hprot, htrans}), exp_ctrl,
                           "address phase control");
                check_addr(haddr, exp_addr, "address phase haddr");
                check_bit(hwrite, exp_write, "address phase hwrite");
                d_active = 1'b1;
                d_idx = haddr[9:2];
                d_write = hwrite;
                d_err = (haddr[31:28] == 4'hF);
                d_left = $urandom_range(0, 3);
                slave_waits = d_left;
            end
            if (d_active && d_left == 0) begin
                hready <= 1'b1;
                hresp <= d_err;
                hrdata <= (d_err || d_write) ? '0 : slave_mem[d_idx];
            end else if (d_active) begin
                hready <= 1'b0;
                hresp <= 1'b0;
                hrdata <= ahb_cap_pkg::word_t'($urandom);  // Junk during waits.
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

    initial begin : main
        ahb_cap_pkg::haddr_t used [6];
        ahb_cap_pkg::word_t  got;
        logic [2:0]          trans;
        void'($urandom(6355));
        rst <= 1'b1;
        start <= 1'b0;
        write <= 1'b0;
        buf_idx <= '0;
        haddr_in <= '0;
        a <= '0;
        b <= '0;
        ctrl_in <= '0;
        ctrl_en <= '0;
        rd_idx <= '0;
        n_cmds = 0;
        n_xfers = 0;
        ref_ctrl = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word(i);
        end
        for (int i = 0; i < num_words; i++) begin
            ref_buf[i] = '0;
        end
        repeat (2) tick();
        rst <= 1'b0;
        for (int i = 0; i < num_words; i++) begin
            read_buf(ahb_cap_pkg::buf_idx_t'(i), got);
            check_word(got, '0, "buffer word after reset");
        end
        check_bit(done, 1'b0, "done after reset");
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(resp, 1'b0, "resp after reset");
        for (int i = 0; i < 6; i++) begin
            used[i] = rand_addr(1'b0);
            run_cmd(1'b1, used[i], ahb_cap_pkg::buf_idx_t'(i), ahb_cap_pkg::word_t'($urandom),
                    ahb_cap_pkg::word_t'($urandom), 3'b010, 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            trans = (i % 2 == 1) ? 3'b011 : 3'b010;
            run_cmd(1'b0, used[i], ahb_cap_pkg::buf_idx_t'(i), '0, '0, trans, 1'b0);
        end
        run_cmd(1'b0, rand_addr(1'b1), 4'd0, '0, '0, 3'b010, 1'b0);
        run_cmd(1'b0, rand_addr(1'b1), 4'd1, '0, '0, 3'b011, 1'b0);
        run_cmd(1'b1, rand_addr(1'b1), 4'd2, 32'hFFFF_FFFF, 32'h1, 3'b010, 1'b0);
        run_cmd(1'b0, used[0], 4'd3, '0, '0, 3'b000, 1'b0);  // IDLE code.
        run_cmd(1'b1, used[1], 4'd4, '0, '0, 3'b001, 1'b0);  // BUSY code.
        run_cmd(1'b0, used[2], 4'd5, '0, '0, 3'b100, 1'b0);
        run_cmd(1'b0, used[2], 4'd9, '0, '0, 3'b010, 1'b1);
        for (int i = 0; i < 10; i++) begin
            case ($urandom_range(0, 3))
                0: trans = 3'b010;
                1: trans = 3'b011;
                2: trans = 3'b110;
                default: trans = 3'b000;
            endcase
            run_cmd($urandom_range(0, 1) == 1, used[$urandom_range(0, 5)],
                    ahb_cap_pkg::buf_idx_t'($urandom_range(0, num_words - 1)),
                    ahb_cap_pkg::word_t'($urandom), ahb_cap_pkg::word_t'($urandom), trans, 1'b0);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/ahb_cap_pkg.sv
logic/ctrl_capture.sv
logic/ahb_master_seq.sv
logic/capture_ram.sv
logic/ahb_cap_top.sv
tests/ahb_cap_asserts.sv
tests/tb_ahb_cap.sv
